//--- design/cbuf_defs.svh
`ifndef CBUF_DEFS_SVH
`define CBUF_DEFS_SVH

// circular buffer and trigger FIFO depths
`define CBUF_AW      10     // 1024 sample pair words
`define TRIG_FIFO_AW 3      // 8 pending triggers

// word tags in the upper nibble of each 132-bit record word
`define TAG_FILL_HDR 4'd0
`define TAG_DATA     4'd1
`define TAG_WFM_HDR  4'd2
`define TAG_CHECKSUM 4'd3

// field positions in the record word
`define TAG_MSB      131
`define TAG_LSB      128
`define PAYLOAD_MSB  127

`endif

//--- design/cbuf_pkg.sv
`include "cbuf_defs.svh"

package cbuf_pkg;

    // two samples plus their over-range bits
    typedef logic [25:0] sample_word_t;

    // circular buffer location
    typedef logic [`CBUF_AW-1:0] cbuf_addr_t;

    // DDR3 burst location, one per record word
    typedef logic [22:0] burst_adr_t;

    typedef logic [22:0] wfm_num_t;         // waveform within a fill
    typedef logic [23:0] fill_num_t;        // fill (event) number
    typedef logic [10:0] num_bursts_t;      // data bursts per waveform
    typedef logic [11:0] pre_trig_t;        // pre-trigger buffer words

    // tag plus payload as written to the DDR3 input FIFO
    typedef logic [`TAG_MSB:0]     acq_word_t;
    typedef logic [`PAYLOAD_MSB:0] payload_t;

endpackage

//--- design/circ_buf.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module circ_buf (
    input  logic                    adc_clk,
    input  logic                    rst_n,
    input  cbuf_pkg::sample_word_t  adc_dat,    // new sample pair every clock
    input  cbuf_pkg::cbuf_addr_t    rd_addr,
    output cbuf_pkg::cbuf_addr_t    wr_addr,    // location written this cycle
    output cbuf_pkg::sample_word_t  rd_dat      // valid one clock after rd_addr
);

    cbuf_pkg::sample_word_t mem [0:(1 << `CBUF_AW)-1];

    // free-running write pointer, wraps at the buffer depth
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n)
            wr_addr <= '0;
        else
            wr_addr <= wr_addr + 1'b1;
    end

    // write port never stops, the buffer always holds the latest samples
    always_ff @(posedge adc_clk) begin
        mem[wr_addr] <= adc_dat;
    end

    always_ff @(posedge adc_clk) begin
        rd_dat <= mem[rd_addr];     // registered read
    end

endmodule

//--- design/trig_fifo.sv
`timescale 1ns/1ps

module trig_fifo #(
    parameter int AW = 3            // log2 of entries
) (
    input  logic                  adc_clk,
    input  logic                  rst_n,
    input  logic                  push,
    input  cbuf_pkg::cbuf_addr_t  push_addr,    // buffer address at the trigger
    input  logic                  pop,
    output cbuf_pkg::cbuf_addr_t  head_addr,    // oldest trigger, valid while !empty
    output logic                  empty
);

    cbuf_pkg::cbuf_addr_t mem [0:(1 << AW)-1];
    logic [AW:0] wr_ptr, rd_ptr;    // extra msb tells full from empty
    logic        full;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // first word falls through, head is read without a pop
    assign head_addr = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push && !full)
                wr_ptr <= wr_ptr + 1'b1;    // trigger dropped when full
            if (pop && !empty)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge adc_clk) begin
        if (push && !full)
            mem[wr_ptr[AW-1:0]] <= push_addr;
    end

endmodule

//--- design/acq_counters.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module acq_counters (
    input  logic                   adc_clk,
    input  logic                   rst_n,
    input  cbuf_pkg::num_bursts_t  async_num_bursts,
    input  cbuf_pkg::fill_num_t    initial_fill_num,
    input  logic                   initial_fill_num_wr,
    input  logic                   burst_adr_init,     // fill start, address goes to 1
    input  logic                   burst_adr_en,       // one step per record word
    input  logic                   burst_cntr_init,
    input  logic                   burst_cntr_en,
    input  logic                   wfm_cntr_init,
    input  logic                   wfm_cntr_en,
    input  logic                   fill_cntr_en,
    input  logic                   save_start_adr,
    input  logic                   save_last_adr,
    output logic                   burst_cntr_zero,
    output cbuf_pkg::wfm_num_t     waveform_num,
    output cbuf_pkg::burst_adr_t   waveform_start_adr,
    output logic [23:0]            num_fill_bursts,
    output cbuf_pkg::fill_num_t    fill_num,
    output logic [23:0]            calc_total_burst_count
);

    cbuf_pkg::burst_adr_t  burst_adr;
    cbuf_pkg::num_bursts_t burst_cntr;
    logic [23:0]           bursts_per_wfm;     // data bursts plus the header

    ////////////////////////////////////////////////////////////
    // record counters
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            burst_adr    <= '0;
            burst_cntr   <= '0;
            waveform_num <= '0;
            fill_num     <= '0;
        end else begin
            if (burst_adr_init)
                burst_adr <= 23'd1;
            else if (burst_adr_en)
                burst_adr <= burst_adr + 1'b1;
            if (burst_cntr_init)
                burst_cntr <= async_num_bursts;
            else if (burst_cntr_en)
                burst_cntr <= burst_cntr - 1'b1;    // counts bursts still to read
            if (wfm_cntr_init)
                waveform_num <= '0;
            else if (wfm_cntr_en)
                waveform_num <= waveform_num + 1'b1;
            if (initial_fill_num_wr)
                fill_num <= initial_fill_num;   // run start
            else if (fill_cntr_en)
                fill_num <= fill_num + 1'b1;
        end
    end

    assign burst_cntr_zero = (burst_cntr == '0);

    ////////////////////////////////////////////////////////////
    // start and total latches
    always_ff @(posedge adc_clk) begin
        if (save_start_adr)
            waveform_start_adr <= burst_adr;    // goes in the waveform header
        if (save_last_adr)
            num_fill_bursts <= 24'(burst_adr) + 24'd1;  // checksum address plus one
    end

    // running prediction of the fill total
    assign bursts_per_wfm         = 24'(async_num_bursts) + 24'd1;
    assign calc_total_burst_count = bursts_per_wfm * 24'(waveform_num) + 24'd2;

endmodule

//--- design/record_mux.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module record_mux (
    input  logic                   adc_clk,
    input  logic                   rst_n,
    input  cbuf_pkg::sample_word_t dat3,           // latest buffer word
    input  cbuf_pkg::sample_word_t dat2,
    input  cbuf_pkg::sample_word_t dat1,
    input  cbuf_pkg::sample_word_t dat0,           // earliest buffer word
    input  logic [15:0]            channel_tag,
    input  logic [1:0]             fill_type,
    input  logic [23:0]            num_fill_bursts,
    input  cbuf_pkg::burst_adr_t   waveform_start_adr,
    input  cbuf_pkg::wfm_num_t     waveform_num,
    input  cbuf_pkg::fill_num_t    fill_num,
    input  cbuf_pkg::num_bursts_t  async_num_bursts,
    input  cbuf_pkg::pre_trig_t    async_pre_trig,
    input  cbuf_pkg::cbuf_addr_t   start_addr,
    input  logic                   select_dat,
    input  logic                   select_fill_hdr,
    input  logic                   select_wfm_hdr,
    input  logic                   select_checksum,
    input  logic                   checksum_init,
    input  logic                   checksum_update,
    output cbuf_pkg::acq_word_t    adc_acq_out_dat
);

    cbuf_pkg::payload_t payload;
    cbuf_pkg::payload_t checksum;
    logic [3:0]         tag;

    ////////////////////////////////////////////////////////////
    // payload packing, everything from bit 0 upward
    always_comb begin
        payload = '0;   // unused bits stay zero
        tag     = `TAG_FILL_HDR;
        if (select_wfm_hdr) begin
            tag     = `TAG_WFM_HDR;
            payload = 128'({start_addr, async_pre_trig, async_num_bursts,
                            waveform_start_adr, waveform_num});
        end else if (select_dat) begin
            tag     = `TAG_DATA;
            payload = 128'({dat3, dat2, dat1, dat0});   // earliest at 25:0
        end else if (select_checksum) begin
            tag     = `TAG_CHECKSUM;
            payload = checksum;
        end else if (select_fill_hdr) begin
            payload = 128'({fill_num, channel_tag, fill_type, waveform_num,
                            num_fill_bursts});
        end
    end

    assign adc_acq_out_dat[`TAG_MSB:`TAG_LSB] = tag;
    assign adc_acq_out_dat[`PAYLOAD_MSB:0]    = payload;

    ////////////////////////////////////////////////////////////
    // running XOR over header and data words of the fill
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n)
            checksum <= '0;
        else if (checksum_init)
            checksum <= '0;
        else if (checksum_update)
            checksum <= checksum ^ payload;
    end

endmodule

//--- design/circ_buf_ctrl_sm.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module circ_buf_ctrl_sm (
    input  logic adc_clk,
    input  logic rst_n,
    input  logic cbuf_rd_en,        // fill open while high
    input  logic trig_fifo_empty,
    input  logic burst_cntr_zero,   // no data bursts left in this waveform
    output logic cbuf_rd_trig_wait,
    output logic trig_addr_rd_en,
    output logic init_rd_addr,
    output logic inc_rd_addr,
    output logic latch_dat,
    output logic adc_acq_out_valid,
    output logic select_dat,
    output logic select_fill_hdr,
    output logic select_wfm_hdr,
    output logic select_checksum,
    output logic checksum_init,
    output logic checksum_update,
    output logic burst_adr_init,
    output logic burst_adr_en,
    output logic burst_cntr_init,
    output logic burst_cntr_en,
    output logic wfm_cntr_init,
    output logic wfm_cntr_en,
    output logic fill_cntr_en,
    output logic save_start_adr,
    output logic save_last_adr
);

    typedef enum logic [3:0] {
        st_idle, st_fill_start, st_wait_trig, st_pop, st_load,
        st_wfm_hdr, st_read4, st_data_out, st_checksum, st_fill_hdr
    } state_t;

    state_t     state, next_state;
    logic [2:0] step;       // cycle within st_read4, 0..4

    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            step  <= '0;
        end else begin
            state <= next_state;
            step  <= (state == st_read4) ? step + 1'b1 : 3'd0;
        end
    end

    ////////////////////////////////////////////////////////////
    // next state and strobes
    always_comb begin
        next_state        = state;
        {cbuf_rd_trig_wait, trig_addr_rd_en, init_rd_addr, inc_rd_addr} = '0;
        {latch_dat, adc_acq_out_valid, select_dat, select_fill_hdr}     = '0;
        {select_wfm_hdr, select_checksum, checksum_init, checksum_update} = '0;
        {burst_adr_init, burst_adr_en, burst_cntr_init, burst_cntr_en}   = '0;
        {wfm_cntr_init, wfm_cntr_en, fill_cntr_en}                       = '0;
        {save_start_adr, save_last_adr}                                  = '0;
        case (state)
            st_idle:
                if (cbuf_rd_en) next_state = st_fill_start;
            st_fill_start: begin    // new fill, restart numbering
                burst_adr_init = 1'b1;
                wfm_cntr_init  = 1'b1;
                checksum_init  = 1'b1;
                next_state     = st_wait_trig;
            end
            st_wait_trig: begin
                cbuf_rd_trig_wait = 1'b1;
                if (!cbuf_rd_en)
                    next_state = st_checksum;   // close the fill
                else if (!trig_fifo_empty)
                    next_state = st_pop;
            end
            st_pop: begin   // start address is captured on this edge
                trig_addr_rd_en = 1'b1;
                save_start_adr  = 1'b1;
                burst_cntr_init = 1'b1;
                next_state      = st_load;
            end
            st_load: begin
                init_rd_addr = 1'b1;
                next_state   = st_wfm_hdr;
            end
            st_wfm_hdr: begin
                adc_acq_out_valid = 1'b1;
                select_wfm_hdr    = 1'b1;
                checksum_update   = 1'b1;
                burst_adr_en      = 1'b1;
                if (burst_cntr_zero) begin  // header-only waveform
                    wfm_cntr_en = 1'b1;
                    next_state  = st_wait_trig;
                end else begin
                    next_state = st_read4;
                end
            end
            st_read4: begin
                inc_rd_addr   = (step < 3'd4);  // four addresses
                latch_dat     = (step != 3'd0); // data trails by a clock
                burst_cntr_en = (step == 3'd0);
                if (step == 3'd4) next_state = st_data_out;
            end
            st_data_out: begin
                adc_acq_out_valid = 1'b1;
                select_dat        = 1'b1;
                checksum_update   = 1'b1;
                burst_adr_en      = 1'b1;
                if (burst_cntr_zero) begin
                    wfm_cntr_en = 1'b1;     // waveform done
                    next_state  = st_wait_trig;
                end else begin
                    next_state = st_read4;
                end
            end
            st_checksum: begin
                adc_acq_out_valid = 1'b1;
                select_checksum   = 1'b1;
                save_last_adr     = 1'b1;
                burst_adr_en      = 1'b1;
                next_state        = st_fill_hdr;
            end
            st_fill_hdr: begin
                adc_acq_out_valid = 1'b1;
                select_fill_hdr   = 1'b1;
                fill_cntr_en      = 1'b1;   // next fill number after the header
                next_state        = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

endmodule

//--- design/circ_buf_to_ddr3.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module circ_buf_to_ddr3 (
    input  logic                   adc_clk,
    input  logic                   rst_n,
    input  logic                   cbuf_rd_en,
    input  logic [15:0]            channel_tag,
    input  cbuf_pkg::fill_num_t    initial_fill_num,
    input  logic                   initial_fill_num_wr,
    input  cbuf_pkg::num_bursts_t  async_num_bursts,
    input  cbuf_pkg::pre_trig_t    async_pre_trig,
    input  cbuf_pkg::sample_word_t circ_buf_rd_dat,
    input  cbuf_pkg::cbuf_addr_t   circ_buf_trig_addr,     // trigger FIFO head
    input  logic                   trig_fifo_empty,
    input  logic [1:0]             fill_type,
    output logic                   cbuf_rd_trig_wait,
    output logic                   trig_addr_rd_en,
    output cbuf_pkg::fill_num_t    fill_num,
    output cbuf_pkg::cbuf_addr_t   circ_buf_rd_addr,
    output cbuf_pkg::acq_word_t    adc_acq_out_dat,
    output logic                   adc_acq_out_valid,
    output logic [23:0]            calc_total_burst_count
);

    cbuf_pkg::cbuf_addr_t   start_addr;
    cbuf_pkg::sample_word_t dat3, dat2, dat1, dat0;
    cbuf_pkg::wfm_num_t     waveform_num;
    cbuf_pkg::burst_adr_t   waveform_start_adr;
    logic [23:0]            num_fill_bursts;
    logic init_rd_addr, inc_rd_addr, latch_dat, burst_cntr_zero;
    logic select_dat, select_fill_hdr, select_wfm_hdr, select_checksum;
    logic checksum_init, checksum_update, save_start_adr, save_last_adr;
    logic burst_adr_init, burst_adr_en, burst_cntr_init, burst_cntr_en;
    logic wfm_cntr_init, wfm_cntr_en, fill_cntr_en;

    ////////////////////////////////////////////////////////////
    // start address and read address counter
    always_ff @(posedge adc_clk or negedge rst_n) begin
        if (!rst_n) begin
            start_addr       <= '0;
            circ_buf_rd_addr <= '0;
        end else begin
            if (trig_addr_rd_en)    // wraps below 0 modulo the depth
                start_addr <= cbuf_pkg::cbuf_addr_t'(circ_buf_trig_addr - async_pre_trig);
            if (init_rd_addr)
                circ_buf_rd_addr <= start_addr;
            else if (inc_rd_addr)
                circ_buf_rd_addr <= circ_buf_rd_addr + 1'b1;
        end
    end

    // four words in, earliest ends up in dat0
    always_ff @(posedge adc_clk) begin
        if (latch_dat) begin
            dat3 <= circ_buf_rd_dat;
            dat2 <= dat3;
            dat1 <= dat2;
            dat0 <= dat1;
        end
    end

    acq_counters u_counters (
        .adc_clk, .rst_n, .async_num_bursts, .initial_fill_num, .initial_fill_num_wr,
        .burst_adr_init, .burst_adr_en, .burst_cntr_init, .burst_cntr_en,
        .wfm_cntr_init, .wfm_cntr_en, .fill_cntr_en, .save_start_adr, .save_last_adr,
        .burst_cntr_zero, .waveform_num, .waveform_start_adr, .num_fill_bursts,
        .fill_num, .calc_total_burst_count
    );

    record_mux u_mux (
        .adc_clk, .rst_n, .dat3, .dat2, .dat1, .dat0, .channel_tag, .fill_type,
        .num_fill_bursts, .waveform_start_adr, .waveform_num, .fill_num,
        .async_num_bursts, .async_pre_trig, .start_addr, .select_dat,
        .select_fill_hdr, .select_wfm_hdr, .select_checksum, .checksum_init,
        .checksum_update, .adc_acq_out_dat
    );

    circ_buf_ctrl_sm u_sm (
        .adc_clk, .rst_n, .cbuf_rd_en, .trig_fifo_empty, .burst_cntr_zero,
        .cbuf_rd_trig_wait, .trig_addr_rd_en, .init_rd_addr, .inc_rd_addr, .latch_dat,
        .adc_acq_out_valid, .select_dat, .select_fill_hdr, .select_wfm_hdr,
        .select_checksum, .checksum_init, .checksum_update, .burst_adr_init,
        .burst_adr_en, .burst_cntr_init, .burst_cntr_en, .wfm_cntr_init,
        .wfm_cntr_en, .fill_cntr_en, .save_start_adr, .save_last_adr
    );

endmodule

//--- design/acq_top.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module acq_top (
    input  logic                   adc_clk,
    input  logic                   rst_n,
    input  cbuf_pkg::sample_word_t adc_dat,
    input  logic                   trig,
    input  logic                   cbuf_rd_en,
    input  logic                   cbuf_trig_en,       // gates new triggers
    input  logic [15:0]            channel_tag,
    input  cbuf_pkg::fill_num_t    initial_fill_num,
    input  logic                   initial_fill_num_wr,
    input  cbuf_pkg::num_bursts_t  async_num_bursts,
    input  cbuf_pkg::pre_trig_t    async_pre_trig,
    input  logic [1:0]             fill_type,
    output logic                   cbuf_rd_trig_wait,
    output cbuf_pkg::fill_num_t    fill_num,
    output cbuf_pkg::acq_word_t    adc_acq_out_dat,
    output logic                   adc_acq_out_valid,
    output logic [23:0]            calc_total_burst_count
);

    cbuf_pkg::cbuf_addr_t   wr_addr, rd_addr, trig_addr;
    cbuf_pkg::sample_word_t rd_dat;
    logic                   trig_fifo_empty, trig_addr_rd_en;

    circ_buf u_cbuf (
        .adc_clk, .rst_n, .adc_dat, .rd_addr, .wr_addr, .rd_dat
    );

    // trigger stores the address being written in the same cycle
    trig_fifo #(.AW(`TRIG_FIFO_AW)) u_trig_fifo (
        .adc_clk, .rst_n,
        .push      (trig & cbuf_trig_en),
        .push_addr (wr_addr),
        .pop       (trig_addr_rd_en),
        .head_addr (trig_addr),
        .empty     (trig_fifo_empty)
    );

    circ_buf_to_ddr3 u_builder (
        .adc_clk, .rst_n, .cbuf_rd_en, .channel_tag, .initial_fill_num,
        .initial_fill_num_wr, .async_num_bursts, .async_pre_trig,
        .circ_buf_rd_dat (rd_dat),
        .circ_buf_trig_addr (trig_addr),
        .trig_fifo_empty, .fill_type, .cbuf_rd_trig_wait, .trig_addr_rd_en, .fill_num,
        .circ_buf_rd_addr (rd_addr),
        .adc_acq_out_dat, .adc_acq_out_valid, .calc_total_burst_count
    );

endmodule

//--- bench/tb_acq.sv
`timescale 1ns/1ps
`include "cbuf_defs.svh"

module tb_acq;

    localparam int MAX_CYCLES = 20000;      // limit on the whole run in clocks
    localparam int DEPTH      = 1 << `CBUF_AW;
    localparam int SHADOW_N   = MAX_CYCLES + 64;

    logic                   adc_clk;
    logic                   rst_n;
    cbuf_pkg::sample_word_t adc_dat;
    logic                   trig, cbuf_rd_en, cbuf_trig_en;
    logic [15:0]            channel_tag;
    cbuf_pkg::fill_num_t    initial_fill_num;
    logic                   initial_fill_num_wr;
    cbuf_pkg::num_bursts_t  async_num_bursts;
    cbuf_pkg::pre_trig_t    async_pre_trig;
    logic [1:0]             fill_type;
    logic                   cbuf_rd_trig_wait;
    cbuf_pkg::fill_num_t    fill_num;
    cbuf_pkg::acq_word_t    adc_acq_out_dat;
    logic                   adc_acq_out_valid;
    logic [23:0]            calc_total_burst_count;

    // sample written at each post-reset write count
    cbuf_pkg::sample_word_t shadow [0:SHADOW_N-1];
    cbuf_pkg::acq_word_t    exp_q [$];      // words the DUT still owes
    cbuf_pkg::acq_word_t    exp_word;
    cbuf_pkg::payload_t     exp_sum;        // running XOR of the fill
    cbuf_pkg::fill_num_t    exp_fill;
    int wcnt, cycles, checks, errors;
    int exp_wfm, exp_badr;

    acq_top DUT (.*);

    initial adc_clk = 1'b0;
    always #5 adc_clk = ~adc_clk;

    ////////////////////////////////////////////////////////////
    // sample feed and write count
    always @(negedge adc_clk) adc_dat <= shadow[wcnt];

    always @(posedge adc_clk) begin
        if (rst_n)
            wcnt <= wcnt + 1;   // buffer address is wcnt mod DEPTH
    end

    // every valid word must be the next one in the queue
    always @(posedge adc_clk) begin
        if (rst_n && adc_acq_out_valid) begin
            checks++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("CHECK FAILED at %0t: unexpected word %h", $time, adc_acq_out_dat);
            end else begin
                exp_word = exp_q.pop_front();
                if (adc_acq_out_dat !== exp_word) begin
                    errors++;
                    $display("CHECK FAILED at %0t: word %h expected %h",
                             $time, adc_acq_out_dat, exp_word);
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // helper tasks start and end on a falling edge
    task automatic step_cycles(input int n);
        repeat (n) @(negedge adc_clk);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] want);
        checks++;
        if (got !== want) begin
            errors++;
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, want);
        end
    endtask

    // header then data bursts for a trigger at write index tidx
    task automatic queue_waveform(input int tidx);
        cbuf_pkg::payload_t p;
        int start;
        start = tidx - int'(async_pre_trig);
        p = '0;
        p[22:0]  = 23'(exp_wfm);
        p[45:23] = 23'(exp_badr);
        p[56:46] = async_num_bursts;
        p[68:57] = async_pre_trig;
        p[78:69] = cbuf_pkg::cbuf_addr_t'(start);  // wraps modulo the depth
        exp_q.push_back({`TAG_WFM_HDR, p});
        exp_sum = exp_sum ^ p;
        exp_badr++;
        for (int k = 0; k < int'(async_num_bursts); k++) begin
            p = '0;
            for (int i = 0; i < 4; i++)
                p[26*i +: 26] = shadow[start + 4*k + i];   // earliest word lowest
            exp_q.push_back({`TAG_DATA, p});
            exp_sum = exp_sum ^ p;
            exp_badr++;
        end
        exp_wfm++;
    endtask

    task automatic pulse_trig;
        trig = 1'b1;
        if (cbuf_trig_en)
            queue_waveform(wcnt);   // pushed with the address written at this edge
        @(negedge adc_clk);
        trig = 1'b0;
    endtask

    task automatic wait_words(input string what);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 500) begin
            @(negedge adc_clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("%s: %0d expected words never came out", what, exp_q.size());
            exp_q.delete();
        end
    endtask

    task automatic open_fill;
        cbuf_rd_en = 1'b1;
        exp_wfm    = 0;
        exp_badr   = 1;     // fill starts at burst 1
        exp_sum    = '0;
        step_cycles(1);
    endtask

    // drain the fill then expect checksum and fill header
    task automatic close_fill(input string what);
        cbuf_pkg::payload_t p;
        int total;
        wait_words(what);
        cbuf_rd_en = 1'b0;
        exp_q.push_back({`TAG_CHECKSUM, exp_sum});
        total = exp_badr + 1;   // checksum sits at exp_badr
        p = '0;
        p[23:0]  = 24'(total);
        p[46:24] = 23'(exp_wfm);
        p[48:47] = fill_type;
        p[64:49] = channel_tag;
        p[88:65] = exp_fill;
        exp_q.push_back({`TAG_FILL_HDR, p});
        wait_words(what);
        check_value({what, " fill_num"}, 64'(fill_num), 64'(exp_fill + 24'd1));
        exp_fill = exp_fill + 24'd1;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    task automatic reset_values;
        step_cycles(1);
        check_value("valid after reset", 64'(adc_acq_out_valid), 64'd0);
        check_value("trig wait after reset", 64'(cbuf_rd_trig_wait), 64'd0);
        // an empty fill still holds the checksum and the fill header
        check_value("total after reset", 64'(calc_total_burst_count), 64'd2);
        check_value("fill_num after reset", 64'(fill_num), 64'd0);
        initial_fill_num_wr = 1'b1;
        step_cycles(1);
        initial_fill_num_wr = 1'b0;
        check_value("fill_num load", 64'(fill_num), 64'(initial_fill_num));
        exp_fill = initial_fill_num;
    endtask

    task automatic single_trigger;
        cbuf_trig_en = 1'b1;
        open_fill();
        step_cycles(10);
        pulse_trig();
        close_fill("single trigger");
    endtask

    task automatic pre_trig_wrap;
        async_pre_trig   = 12'd20;
        async_num_bursts = 11'd6;   // 24 words so the read also crosses the buffer end
        open_fill();
        while (wcnt != DEPTH + 2)
            @(negedge adc_clk);     // trigger lands at address 2 and the start at 1006
        pulse_trig();
        close_fill("pre-trigger wrap");
    endtask

    task automatic three_triggers;
        async_pre_trig   = 12'd9;
        async_num_bursts = 11'd2;
        open_fill();
        repeat (3) begin
            pulse_trig();
            step_cycles(2);
        end
        wait_words("three triggers");
        // checksum would go at exp_badr, the total is one more
        check_value("running total", 64'(calc_total_burst_count), 64'(exp_badr + 1));
        close_fill("three triggers");
    endtask

    task automatic disabled_triggers;
        cbuf_trig_en = 1'b0;
        open_fill();
        step_cycles(3);
        check_value("trig wait in open fill", 64'(cbuf_rd_trig_wait), 64'd1);
        pulse_trig();
        step_cycles(3);
        pulse_trig();
        step_cycles(30);    // gated triggers must not start a waveform
        check_value("trig wait still idle", 64'(cbuf_rd_trig_wait), 64'd1);
        close_fill("disabled triggers");
        check_value("trig wait after fill", 64'(cbuf_rd_trig_wait), 64'd0);
    endtask

    task automatic finish_run;
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    endtask

    ////////////////////////////////////////////////////////////
    // run limit
    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge adc_clk);
            cycles++;
        end
        errors++;
        $display("timeout: run stopped after %0d cycles", cycles);
        finish_run();
    end

    initial begin
        void'($urandom(32'hd48e5f27));
        for (int i = 0; i < SHADOW_N; i++)
            shadow[i] = cbuf_pkg::sample_word_t'($urandom);
        wcnt                = 0;
        checks              = 0;
        errors              = 0;
        exp_wfm             = 0;
        exp_badr            = 1;
        exp_sum             = '0;
        exp_fill            = '0;
        rst_n               = 1'b0;
        adc_dat             = shadow[0];
        trig                = 1'b0;
        cbuf_rd_en          = 1'b0;
        cbuf_trig_en        = 1'b0;
        channel_tag         = 16'h5a3c;
        initial_fill_num    = 24'h000107;
        initial_fill_num_wr = 1'b0;
        async_num_bursts    = 11'd3;
        async_pre_trig      = 12'd5;
        fill_type           = 2'd1;
        step_cycles(4);     // reset over four clocks
        rst_n = 1'b1;
        reset_values();
        single_trigger();
        pre_trig_wrap();           // second fill restarts the numbering
        three_triggers();
        disabled_triggers();
        step_cycles(5);
        finish_run();
    end

endmodule

//--- files.f
+incdir+design
design/cbuf_pkg.sv
design/circ_buf.sv
design/trig_fifo.sv
design/acq_counters.sv
design/record_mux.sv
design/circ_buf_ctrl_sm.sv
design/circ_buf_to_ddr3.sv
design/acq_top.sv
bench/tb_acq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only if the pass line is printed
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_acq -f files.f -o tb_acq_sim \
    && ./obj_dir/tb_acq_sim | tee /dev/stderr | grep -x "Everything OK" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
